// File: common/memtest_config.svh
// field widths, address steps, test ranges and read queue depth
// for the memory test engine
`ifndef MEMTEST_CONFIG_SVH
`define MEMTEST_CONFIG_SVH

// address field widths, kept small so a full walk stays short
`define MT_ROW_BITS    6
`define MT_COL_BITS    5
`define MT_BANK_BITS   2

// row advances by bus width in bytes (32 bit bus)
`define MT_ROW_STEP    4
// column advances by one burst
`define MT_COL_STEP    8

// column range of the test region, stop is the last column covered
`define MT_COL_START   0
`define MT_COL_STOP    31

// bank range, both ends inclusive
`define MT_BANK_START  0
`define MT_BANK_STOP   3

// controller data width
`define MT_DATA_BITS   32

// outstanding reads the tracker can hold
`define MT_RD_DEPTH    8

`endif

// File: common/memtest_pkg.sv
// address and data types, test phase encoding and the
// address-derived test pattern
`include "memtest_config.svh"

package memtest_pkg;

	//------------------------------------------------------------------------
	// address layout  cs | pad | row | bank | col | datapath
	//------------------------------------------------------------------------
	localparam int adrsBits    = 33;
	localparam int adrsCsBits  = 1;
	localparam int adrsDpBits  = 2;                     // datapath bits, always zero
	localparam int adrsPadBits = adrsBits - adrsCsBits - `MT_ROW_BITS
		- `MT_BANK_BITS - `MT_COL_BITS - adrsDpBits;

	localparam int dataBits = `MT_DATA_BITS;
	localparam int rotBits  = $clog2(dataBits);         // seed bits used as rotate count

	typedef logic [adrsBits-1:0] memAdrs_t;
	typedef logic [dataBits-1:0] memData_t;

	// run phases of the sequencer
	typedef enum logic [2:0]
	{
		phIdle,
		phWrite,
		phRead,
		phDrain,
		phFinish
	} testPhase_t;

	//------------------------------------------------------------------------
	// pattern for one address
	//------------------------------------------------------------------------
	// address bits folded into the data width, rotated left by the low
	// seed bits, then xored with the whole seed
	function automatic memData_t patternOf(memAdrs_t adrs, memData_t seed);
		memData_t    base;
		int unsigned sh;
		base = memData_t'(adrs);                        // cs bit drops off, always zero
		sh   = seed[rotBits-1:0];
		// shift by full width gives zero, so sh == 0 is plain base
		return ((base << sh) | (base >> (dataBits - sh))) ^ seed;
	endfunction

endpackage

// File: design/memAdrsGen.sv
// test region address stepper, row then column then bank,
// with one-cycle done pulse after the last address
`timescale 1ns/1ps
`include "memtest_config.svh"

module memAdrsGen
(
	input  logic                 iCLK,
	input  logic                 iRST,
	input  logic                 step,      // advance to next address
	input  logic                 restart,   // reload start address
	output memtest_pkg::memAdrs_t adrs,
	output logic                 wrapDone   // one cycle, after last address left
);
	import memtest_pkg::*;

	localparam int rowBits  = `MT_ROW_BITS;
	localparam int colBits  = `MT_COL_BITS;
	localparam int bankBits = `MT_BANK_BITS;

	//------------------------------------------------------------------------
	// step sizes and last values of each field
	//------------------------------------------------------------------------
	localparam logic [rowBits-1:0]  rowStep   = rowBits'(`MT_ROW_STEP);
	localparam logic [rowBits-1:0]  rowLast   = rowBits'((1 << rowBits) - `MT_ROW_STEP);
	localparam logic [colBits-1:0]  colStep   = colBits'(`MT_COL_STEP);
	localparam logic [colBits-1:0]  colStart  = colBits'(`MT_COL_START);
	// last column inside the range, one burst below stop + 1
	localparam logic [colBits-1:0]  colLast   =
		colBits'(`MT_COL_STOP + 1 - `MT_COL_STEP);
	localparam logic [bankBits-1:0] bankStart = bankBits'(`MT_BANK_START);
	localparam logic [bankBits-1:0] bankLast  = bankBits'(`MT_BANK_STOP);

	logic [rowBits-1:0]  row;
	logic [colBits-1:0]  col;
	logic [bankBits-1:0] bank;

	logic rowWrap;     // row leaves its last value
	logic colWrap;     // column leaves its last value
	logic adrsWrap;    // whole region done

	// carry chain, each level only on a real step
	assign rowWrap  = step & (row == rowLast);
	assign colWrap  = rowWrap & (col == colLast);
	assign adrsWrap = colWrap & (bank == bankLast);

	//------------------------------------------------------------------------
	// field counters
	//------------------------------------------------------------------------
	always_ff @(posedge iCLK)
	begin
		if (iRST | restart)
		begin
			row      <= '0;
			col      <= colStart;
			bank     <= bankStart;
			wrapDone <= 1'b0;
		end
		else
		begin
			wrapDone <= adrsWrap;                       // back at start when this is seen

			if (step)
				row <= rowWrap ? '0 : row + rowStep;

			if (rowWrap)
				col <= colWrap ? colStart : col + colStep;

			if (colWrap)
				bank <= adrsWrap ? bankStart : bank + 1'b1;
		end
	end

	// cs and datapath bits stay zero
	assign adrs = {1'b0, {adrsPadBits{1'b0}}, row, bank, col, {adrsDpBits{1'b0}}};

endmodule

// File: design/memTestSeq.sv
// run sequencer: idle, write, read, drain and finish phases,
// memory strobes, address steps and read tracker pushes
`timescale 1ns/1ps

module memTestSeq
(
	input  logic                   iCLK,
	input  logic                   iRST,
	input  logic                   iStart,     // begins a run
	input  memtest_pkg::memData_t  iSeed,      // pattern seed, sampled at start
	input  logic                   iMemReady,  // controller accepts a strobe
	input  logic                   wrapDone,   // stepper finished the region
	input  logic                   full,       // read tracker has no room
	input  logic                   checkDone,  // read tracker empty
	output logic                   oMemWr,
	output logic                   oMemRd,
	output logic                   step,
	output logic                   restart,
	output logic                   push,
	output logic                   oBusy,
	output logic                   oDone,
	output memtest_pkg::memData_t  seed,
	output memtest_pkg::testPhase_t phase
);
	import memtest_pkg::*;

	logic startGo;   // start accepted this cycle
	logic wrGo;      // write strobe issued
	logic rdGo;      // read strobe issued
	logic canStart;  // not inside a run

	//------------------------------------------------------------------------
	// strobe decode
	//------------------------------------------------------------------------
	assign canStart = (phase == phIdle) | (phase == phFinish);
	assign startGo  = iStart & canStart;

	// the wrapDone cycle issues nothing, stepper sits at start again
	// and the phase changes on this edge
	assign wrGo = (phase == phWrite) & iMemReady & ~wrapDone;
	assign rdGo = (phase == phRead) & iMemReady & ~full & ~wrapDone;

	assign oMemWr  = wrGo;
	assign oMemRd  = rdGo;
	assign step    = wrGo | rdGo;          // one address per issued strobe
	assign push    = rdGo;                 // remember read address for check
	assign restart = startGo;              // also clears the checker

	assign oBusy = (phase == phWrite) | (phase == phRead) | (phase == phDrain);

	//------------------------------------------------------------------------
	// phase register
	//------------------------------------------------------------------------
	always_ff @(posedge iCLK)
	begin
		if (iRST)
		begin
			phase <= phIdle;
			oDone <= 1'b0;
		end
		else
		begin
			oDone <= 1'b0;                     // pulse only
			case (phase)
				phIdle, phFinish:
				begin
					if (iStart)
						phase <= phWrite;
				end
				phWrite:
				begin
					if (wrapDone)
						phase <= phRead;       // all writes out
				end
				phRead:
				begin
					if (wrapDone)
						phase <= phDrain;      // all reads out, returns pending
				end
				phDrain:
				begin
					if (checkDone)             // last return popped and checked
					begin
						phase <= phFinish;
						oDone <= 1'b1;
					end
				end
				default:
				begin
					phase <= phIdle;
				end
			endcase
		end
	end

	//------------------------------------------------------------------------
	// seed for this run
	//------------------------------------------------------------------------
	always_ff @(posedge iCLK)
	begin
		if (startGo)
			seed <= iSeed;
	end

endmodule

// File: design/memRdTracker.sv
// in-order queue of outstanding read addresses
// circular buffer with read and write pointers and occupancy count
`timescale 1ns/1ps
`include "memtest_config.svh"

module memRdTracker
(
	input  logic                  iCLK,
	input  logic                  iRST,
	input  logic                  push,      // read issued
	input  logic                  pop,       // read returned
	input  memtest_pkg::memAdrs_t pushAdrs,
	output memtest_pkg::memAdrs_t headAdrs,  // address of oldest pending read
	output logic                  full,
	output logic                  empty
);
	import memtest_pkg::*;

	localparam int depth   = `MT_RD_DEPTH;
	localparam int ptrBits = $clog2(depth);
	localparam int cntBits = $clog2(depth + 1);

	memAdrs_t           mem [depth];
	logic [ptrBits-1:0] wrPtr;
	logic [ptrBits-1:0] rdPtr;
	logic [cntBits-1:0] count;
	logic               wrEn;
	logic               rdEn;

	assign wrEn = push & ~full;
	assign rdEn = pop & ~empty;

	assign full     = (count == cntBits'(depth));
	assign empty    = (count == '0);
	assign headAdrs = mem[rdPtr];

	// address storage
	always_ff @(posedge iCLK)
	begin
		if (wrEn)
			mem[wrPtr] <= pushAdrs;
	end

	//------------------------------------------------------------------------
	// pointers and occupancy
	//------------------------------------------------------------------------
	always_ff @(posedge iCLK)
	begin
		if (iRST)
		begin
			wrPtr <= '0;
			rdPtr <= '0;
			count <= '0;
		end
		else
		begin
			if (wrEn)
				wrPtr <= (wrPtr == ptrBits'(depth - 1)) ? '0 : wrPtr + 1'b1;
			if (rdEn)
				rdPtr <= (rdPtr == ptrBits'(depth - 1)) ? '0 : rdPtr + 1'b1;
			// push and pop together leave count as is
			if (wrEn & ~rdEn)
				count <= count + 1'b1;
			else if (rdEn & ~wrEn)
				count <= count - 1'b1;
		end
	end

endmodule

// File: design/memRdCheck.sv
// read data checker: compare against pattern of the head address,
// saturating error count, first failing address and pass flag
`timescale 1ns/1ps

module memRdCheck
(
	input  logic                  iCLK,
	input  logic                  iRST,
	input  logic                  clear,        // new run
	input  logic                  iMemRdValid,  // one return, in issue order
	input  memtest_pkg::memData_t iMemRdData,
	input  memtest_pkg::memAdrs_t headAdrs,     // address this return belongs to
	input  memtest_pkg::memData_t seed,
	output logic                  pop,
	output logic [15:0]           oErrCount,
	output memtest_pkg::memAdrs_t oFailAdrs,
	output logic                  oPass
);
	import memtest_pkg::*;

	memData_t expData;
	logic     mismatch;
	logic     errSat;     // counter at its top value

	// every return retires the oldest pending read
	assign pop = iMemRdValid;

	assign expData  = patternOf(headAdrs, seed);
	assign mismatch = iMemRdValid & (iMemRdData != expData);
	assign errSat   = &oErrCount;

	//------------------------------------------------------------------------
	// error count and first failing address
	//------------------------------------------------------------------------
	always_ff @(posedge iCLK)
	begin
		if (iRST | clear)
		begin
			oErrCount <= '0;
			oFailAdrs <= '0;
		end
		else if (mismatch)
		begin
			if (!errSat)
				oErrCount <= oErrCount + 1'b1;  // visible one cycle after valid
			if (oErrCount == '0)
				oFailAdrs <= headAdrs;          // only the first one kept
		end
	end

	assign oPass = (oErrCount == '0);

endmodule

// File: design/memTestTop.sv
// memory test engine top: sequencer, address stepper,
// read tracker and read checker
`timescale 1ns/1ps

module memTestTop
(
	input  logic                  iCLK,
	input  logic                  iRST,
	input  logic                  iStart,
	input  memtest_pkg::memData_t iSeed,
	input  logic                  iMemReady,
	input  logic                  iMemRdValid,
	input  memtest_pkg::memData_t iMemRdData,
	output logic                  oMemWr,
	output logic                  oMemRd,
	output memtest_pkg::memAdrs_t oMemAdrs,
	output memtest_pkg::memData_t oMemWrData,
	output logic                  oBusy,
	output logic                  oDone,
	output logic                  oPass,
	output logic [15:0]           oErrCount,
	output memtest_pkg::memAdrs_t oFailAdrs
);
	import memtest_pkg::*;

	logic       step;
	logic       restart;
	logic       push;
	logic       pop;
	logic       wrapDone;
	logic       full;
	logic       empty;
	memAdrs_t   adrs;
	memAdrs_t   headAdrs;
	memData_t   seed;
	testPhase_t phase;

	//------------------------------------------------------------------------
	// controller side
	//------------------------------------------------------------------------
	assign oMemAdrs   = adrs;
	// write data only in the write phase, zero otherwise
	assign oMemWrData = (phase == phWrite) ? patternOf(adrs, seed) : '0;

	memTestSeq uSeq
	(
		.iCLK      (iCLK),
		.iRST      (iRST),
		.iStart    (iStart),
		.iSeed     (iSeed),
		.iMemReady (iMemReady),
		.wrapDone  (wrapDone),
		.full      (full),
		.checkDone (empty),         // drain ends when nothing is pending
		.oMemWr    (oMemWr),
		.oMemRd    (oMemRd),
		.step      (step),
		.restart   (restart),
		.push      (push),
		.oBusy     (oBusy),
		.oDone     (oDone),
		.seed      (seed),
		.phase     (phase)
	);

	memAdrsGen uAdrsGen
	(
		.iCLK     (iCLK),
		.iRST     (iRST),
		.step     (step),
		.restart  (restart),
		.adrs     (adrs),
		.wrapDone (wrapDone)
	);

	memRdTracker uRdTracker
	(
		.iCLK     (iCLK),
		.iRST     (iRST),
		.push     (push),
		.pop      (pop),
		.pushAdrs (adrs),
		.headAdrs (headAdrs),
		.full     (full),
		.empty    (empty)
	);

	memRdCheck uRdCheck
	(
		.iCLK        (iCLK),
		.iRST        (iRST),
		.clear       (restart),     // status cleared at every start
		.iMemRdValid (iMemRdValid),
		.iMemRdData  (iMemRdData),
		.headAdrs    (headAdrs),
		.seed        (seed),
		.pop         (pop),
		.oErrCount   (oErrCount),
		.oFailAdrs   (oFailAdrs),
		.oPass       (oPass)
	);

endmodule

// File: sim/tbMemModel.sv
// behavioral DRAM controller for the memory test engine
// random ready stalls, random in-order read latency, one injectable fault
`timescale 1ns/1ps
`include "memtest_config.svh"

module tbMemModel
#(
	parameter logic [15:0] lfsrSeed   = 16'd45,
	parameter int          maxLatency = 8       // power of two
)
(
	input  logic                  iCLK,
	input  logic                  iRST,
	input  logic                  memWr,
	input  logic                  memRd,
	input  memtest_pkg::memAdrs_t adrs,
	input  memtest_pkg::memData_t wrData,
	input  logic                  faultEn,     // corrupt reads of faultAdrs
	input  memtest_pkg::memAdrs_t faultAdrs,
	output logic                  ready,
	output logic                  rdValid,
	output memtest_pkg::memData_t rdData
);
	import memtest_pkg::*;

	localparam int latBits = $clog2(maxLatency);

	memData_t    mem [memAdrs_t];   // sparse storage
	memAdrs_t    pendAdrs [$];      // reads in issue order
	int          pendDue [$];       // cycle each read may return
	int          cyc;
	int          lastDue;
	logic [15:0] lfsr = lfsrSeed;

	// fibonacci lfsr, taps 16 14 13 11
	function automatic logic [15:0] lfsrStep(logic [15:0] s);
		return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
	endfunction

	// one lfsr step per bit taken
	task automatic takeBits(input int n, output int unsigned v);
		v = 0;
		for (int i = 0; i < n; i++)
		begin
			lfsr = lfsrStep(lfsr);
			v    = (v << 1) | lfsr[0];
		end
	endtask

	//------------------------------------------------------------------------
	// strobes sampled on the rising edge
	//------------------------------------------------------------------------
	always @(posedge iCLK)
	begin
		int unsigned lat;
		int          due;
		if (iRST)
		begin
			cyc     = 0;
			lastDue = 0;
			pendAdrs.delete();
			pendDue.delete();
		end
		else
		begin
			cyc = cyc + 1;
			if (memWr)
				mem[adrs] = wrData;
			if (memRd)
			begin
				takeBits(latBits, lat);                 // 1 .. maxLatency cycles
				due = cyc + 1 + int'(lat);
				if (due <= lastDue)
					due = lastDue + 1;                  // keep returns in order
				lastDue = due;
				pendAdrs.push_back(adrs);
				pendDue.push_back(due);
			end
		end
	end

	//------------------------------------------------------------------------
	// ready and read returns driven on the falling edge
	//------------------------------------------------------------------------
	initial
	begin : drive
		int unsigned r;
		memAdrs_t    a;
		memData_t    d;
		ready   = 1'b0;
		rdValid = 1'b0;
		rdData  = '0;
		forever
		begin
			@(negedge iCLK);
			rdValid = 1'b0;
			rdData  = '0;
			if (iRST)
				ready = 1'b0;
			else
			begin
				takeBits(2, r);
				ready = (r != 0);                       // stall about one cycle in four
				if (pendDue.size() > 0 && pendDue[0] <= cyc)
				begin
					a = pendAdrs.pop_front();
					void'(pendDue.pop_front());
					d = mem.exists(a) ? mem[a] : '0;
					if (faultEn && a == faultAdrs)
						d[0] = ~d[0];                   // single stuck bit
					rdValid = 1'b1;
					rdData  = d;
				end
			end
		end
	end

endmodule

// File: sim/tbMemTest.sv
// testbench for the memory test engine: reference walk, strobe monitor,
// clean run, fault run, watchdog and summary
`timescale 1ns/1ps
`include "memtest_config.svh"

module tbMemTest;
	import memtest_pkg::*;

	localparam int rowBits    = `MT_ROW_BITS;
	localparam int colBits    = `MT_COL_BITS;
	localparam int bankBits   = `MT_BANK_BITS;
	localparam int dataBits   = `MT_DATA_BITS;
	localparam int padBits    = 33 - 1 - rowBits - bankBits - colBits - 2;
	localparam int numRows    = (1 << rowBits) / `MT_ROW_STEP;
	localparam int numCols    = (`MT_COL_STOP + 1 - `MT_COL_START) / `MT_COL_STEP;
	localparam int numBanks   = `MT_BANK_STOP - `MT_BANK_START + 1;
	localparam int numAdrs    = numRows * numCols * numBanks;
	localparam int maxLatency = 8;
	localparam int faultIdx   = 77;              // location hit in the fault run
	// two runs, each write and read pass bounded by worst latency
	localparam int watchCycles = 16 + 2 * (numAdrs * 2 * maxLatency + 500);

	logic     iCLK;
	logic     iRST;
	logic     iStart;
	memData_t iSeed;
	logic     memReady;
	logic     memRdValid;
	memData_t memRdData;
	logic     memWr;
	logic     memRd;
	memAdrs_t memAdrs;
	memData_t memWrData;
	logic     busy;
	logic     done;
	logic     pass;
	logic [15:0] errCount;
	memAdrs_t failAdrs;
	logic     faultEn;
	memAdrs_t faultAdrs;

	memAdrs_t walk [numAdrs];                    // expected address order
	memData_t runSeed;
	int       wrIdx;
	int       rdIdx;
	int       pending;                           // reads without a return yet
	int       valueErrs = 0;
	int       otherErrs = 0;

	memTestTop i_dut
	(
		.iCLK        (iCLK),
		.iRST        (iRST),
		.iStart      (iStart),
		.iSeed       (iSeed),
		.iMemReady   (memReady),
		.iMemRdValid (memRdValid),
		.iMemRdData  (memRdData),
		.oMemWr      (memWr),
		.oMemRd      (memRd),
		.oMemAdrs    (memAdrs),
		.oMemWrData  (memWrData),
		.oBusy       (busy),
		.oDone       (done),
		.oPass       (pass),
		.oErrCount   (errCount),
		.oFailAdrs   (failAdrs)
	);

	tbMemModel #(.lfsrSeed(16'd45), .maxLatency(maxLatency)) uModel
	(
		.iCLK      (iCLK),
		.iRST      (iRST),
		.memWr     (memWr),
		.memRd     (memRd),
		.adrs      (memAdrs),
		.wrData    (memWrData),
		.faultEn   (faultEn),
		.faultAdrs (faultAdrs),
		.ready     (memReady),
		.rdValid   (memRdValid),
		.rdData    (memRdData)
	);

	initial
	begin
		iCLK = 1'b0;
		forever #50 iCLK = ~iCLK;
	end

	//------------------------------------------------------------------------
	// reference model helpers
	//------------------------------------------------------------------------
	task automatic mismatch(input string name, input logic [63:0] exp, input logic [63:0] act);
		valueErrs++;
		$display("FAIL %s expected %0h actual %0h", name, exp, act);
	endtask

	task automatic violation(input string what);
		otherErrs++;
		$display("ERROR %s", what);
	endtask

	// cs | pad | row | bank | col | two datapath zeros
	function automatic memAdrs_t makeAdrs(int r, int b, int c);
		return {1'b0, {padBits{1'b0}}, rowBits'(r), bankBits'(b), colBits'(c), 2'b00};
	endfunction

	// low address bits rotated left by the seed's low bits, then xor seed
	function automatic memData_t expectedData(memAdrs_t a, memData_t s);
		memData_t base;
		memData_t rot;
		int       sh;
		base = a[dataBits-1:0];
		sh   = int'(s[$clog2(dataBits)-1:0]);
		for (int i = 0; i < dataBits; i++)
			rot[(i + sh) % dataBits] = base[i];
		return rot ^ s;
	endfunction

	// row fastest, then column, then bank
	task automatic buildWalk();
		int idx;
		idx = 0;
		for (int b = `MT_BANK_START; b <= `MT_BANK_STOP; b++)
			for (int c = `MT_COL_START; c + `MT_COL_STEP <= `MT_COL_STOP + 1; c += `MT_COL_STEP)
				for (int r = 0; r < (1 << rowBits); r += `MT_ROW_STEP)
				begin
					walk[idx] = makeAdrs(r, b, c);
					idx++;
				end
	endtask

	//------------------------------------------------------------------------
	// strobe monitor, sampled on the rising edge
	//------------------------------------------------------------------------
	always @(posedge iCLK)
	begin
		if (!iRST)
		begin
			if (iStart)
			begin
				wrIdx   = 0;
				rdIdx   = 0;
				pending = 0;
				runSeed = iSeed;                        // same sample point as the DUT
			end
			if (memWr)
			begin
				assert (memReady) else violation("write strobe while ready was low");
				assert (wrIdx < numAdrs) else violation("write strobe past end of region");
				if (wrIdx < numAdrs)
				begin
					assert (memAdrs == walk[wrIdx])
					else mismatch("write address", walk[wrIdx], memAdrs);
					assert (memWrData == expectedData(walk[wrIdx], runSeed))
					else mismatch("write data", expectedData(walk[wrIdx], runSeed), memWrData);
				end
				wrIdx++;
			end
			if (memRd)
			begin
				assert (memReady) else violation("read strobe while ready was low");
				assert (rdIdx < numAdrs) else violation("read strobe past end of region");
				if (rdIdx < numAdrs)
				begin
					assert (memAdrs == walk[rdIdx])
					else mismatch("read address", walk[rdIdx], memAdrs);
				end
				rdIdx++;
				pending++;
			end
			if (memRdValid)
				pending--;
			assert (pending <= `MT_RD_DEPTH) else violation("outstanding reads above queue depth");
		end
	end

	//------------------------------------------------------------------------
	// one full run and its closing checks
	//------------------------------------------------------------------------
	task automatic runTest(input string name, input memData_t seed, input logic inject,
		input memAdrs_t badAdrs, input int expErrs);
		@(negedge iCLK);
		iSeed     = seed;
		faultEn   = inject;
		faultAdrs = badAdrs;
		iStart    = 1'b1;
		@(negedge iCLK);
		iStart = 1'b0;
		do
			@(negedge iCLK);
		while (!done);
		assert (wrIdx == numAdrs) else mismatch({name, " write count"}, numAdrs, wrIdx);
		assert (rdIdx == numAdrs) else mismatch({name, " read count"}, numAdrs, rdIdx);
		assert (pending == 0) else mismatch({name, " reads left pending"}, 0, pending);
		assert (!busy) else violation({name, " busy still high after done"});
		assert (errCount == 16'(expErrs)) else mismatch({name, " error count"}, expErrs, errCount);
		assert (pass == (expErrs == 0)) else mismatch({name, " pass flag"}, expErrs == 0, pass);
		if (inject)
		begin
			assert (failAdrs == badAdrs) else mismatch({name, " fail address"}, badAdrs, failAdrs);
		end
	endtask

	initial
	begin : stimulus
		memAdrs_t badAdrs;
		iRST      = 1'b1;
		iStart    = 1'b0;
		iSeed     = '0;
		faultEn   = 1'b0;
		faultAdrs = '0;
		buildWalk();
		badAdrs = walk[faultIdx];
		repeat (16) @(negedge iCLK);
		iRST = 1'b0;
		@(negedge iCLK);
		assert (!memWr && !memRd && !busy && !done)
		else violation("strobes or status high after reset");
		assert (errCount == 16'd0) else mismatch("error count after reset", 0, errCount);

		runTest("clean run", 32'hA5C3_0F13, 1'b0, '0, 0);
		runTest("fault run", 32'h3C96_E5A7, 1'b1, badAdrs, 1);   // different seed

		$display("errors: %0d value, %0d other", valueErrs, otherErrs);
		if (valueErrs + otherErrs == 0)
			$display("TB PASSED");
		else
			$display("TB FAILED");
		$finish;
	end

	initial
	begin : watchdog
		repeat (watchCycles) @(posedge iCLK);
		$display("watchdog expired after %0d cycles, run never finished", watchCycles);
		$display("TB FAILED");
		$finish;
	end

endmodule

// File: list.f
+incdir+common
common/memtest_pkg.sv
design/memAdrsGen.sv
design/memTestSeq.sv
design/memRdTracker.sv
design/memRdCheck.sv
design/memTestTop.sv
sim/tbMemModel.sv
sim/tbMemTest.sv

// File: Makefile
SIM      = verilator
FLAGS    = --binary --timing --assert -Wno-fatal
TOP      = tbMemTest
FILELIST = list.f
OBJDIR   = obj_dir

.PHONY: sim clean

sim:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)
	@out="$$(./$(OBJDIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "TB PASSED"

clean:
	rm -rf $(OBJDIR)
